/* tb.f */
+incdir+design
design/video_pkg.sv
design/vga_timing_pkg.sv
design/pattern_core.sv
design/line_buffer.sv
design/vga_scanout.sv
design/video_system_linebuffer.sv
verif/video_system_chk.sv
verif/tb_video_system.sv

/* verif/tb_video_system.sv */
`timescale 1ns/1ps

`include "video_defines.svh"

module tb_video_system;

    localparam int CLK_HALF  = 20;
    localparam int LINE_CYC  = 2 * `H_TOTAL;
    localparam int FRAME_CYC = LINE_CYC * `V_TOTAL;
    localparam int CH_MAX    = (1 << `CH_SIZE) - 1;
    localparam int SIG_DE    = 0;
    localparam int SIG_HSYNC = 1;
    localparam int SIG_VSYNC = 2;
    // Bar colours as {r,g,b} on bits with bar 7 in the top bits
    localparam logic [23:0] BAR_MASKS = {3'b000, 3'b001, 3'b100, 3'b101,
                                         3'b010, 3'b011, 3'b110, 3'b111};

    logic               sys_clk;
    logic               reset;
    logic               bar_bypass;
    logic               gray_bypass;
    video_pkg::chan_t   vga_r;
    video_pkg::chan_t   vga_g;
    video_pkg::chan_t   vga_b;
    logic               vga_hsync;
    logic               vga_vsync;
    logic               vga_de;
    int                 seed;
    int                 line_pick;

    video_system_linebuffer i_video_system_linebuffer (
        .sys_clk     (sys_clk),
        .reset       (reset),
        .bar_bypass  (bar_bypass),
        .gray_bypass (gray_bypass),
        .vga_r       (vga_r),
        .vga_g       (vga_g),
        .vga_b       (vga_b),
        .vga_hsync   (vga_hsync),
        .vga_vsync   (vga_vsync),
        .vga_de      (vga_de)
    );

    // 40 ns clock
    initial begin
        sys_clk = 1'b0;
        forever #CLK_HALF sys_clk = ~sys_clk;
    end

    // ------------------------------------------------------------------------
    // Failure reporting and compare tasks
    // ------------------------------------------------------------------------

    task automatic stop_with_failure();
        $display("Test failed");
        $fatal(1, "Simulation stopped on a failed check");
    endtask

    task automatic report_timeout(input string what);
        $display("Timed out waiting for %s at %0d ns", what, $time);
        stop_with_failure();
    endtask

    task automatic check_rgb(input video_pkg::rgb_t got, input video_pkg::rgb_t exp,
                             input string what);
        if (got !== exp) begin
            $display("error at %0d ns: %s got r=%0d g=%0d b=%0d expected r=%0d g=%0d b=%0d",
                     $time, what, got.r, got.g, got.b, exp.r, exp.g, exp.b);
            stop_with_failure();
        end
    endtask

    task automatic check_count(input vga_timing_pkg::hcount_t got,
                               input vga_timing_pkg::hcount_t exp, input string what);
        if (got !== exp) begin
            $display("error at %0d ns: %s got %0d expected %0d", $time, what, got, exp);
            stop_with_failure();
        end
    endtask

    task automatic check_flag(input logic got, input logic exp, input string what);
        if (got !== exp) begin
            $display("error at %0d ns: %s got %b expected %b", $time, what, got, exp);
            stop_with_failure();
        end
    endtask

    // Stop at the first bound assertion failure
    always @(negedge sys_clk) begin
        if (i_video_system_linebuffer.u_line_buffer.i_chk_fifo.fail_count != 0 ||
            i_video_system_linebuffer.u_vga_scanout.i_chk_scan.fail_count != 0) begin
            $display("Bound checker reported an assertion failure at %0d ns", $time);
            stop_with_failure();
        end
    end

    // ------------------------------------------------------------------------
    // Reference model and waits
    // ------------------------------------------------------------------------

    // Ramp then bar overlay then gray as seen at the VGA pins
    function automatic video_pkg::rgb_t expected_rgb(input int x, input int y,
                                                     input logic bar_byp, input logic gray_byp);
        int               r;
        int               g;
        int               b;
        int               gray;
        logic [2:0]       mask;
        video_pkg::rgb_t  res;
        r = x;
        g = 4 * y;
        b = CH_MAX - x;
        if (!bar_byp) begin
            mask = BAR_MASKS[(x / `BAR_WIDTH) * 3 +: 3];
            r = mask[2] ? CH_MAX : 0;
            g = mask[1] ? CH_MAX : 0;
            b = mask[0] ? CH_MAX : 0;
        end
        if (!gray_byp) begin
            gray = (r + 2 * g + b) / 4;
            r = gray;
            g = gray;
            b = gray;
        end
        res.r = video_pkg::chan_t'(r);
        res.g = video_pkg::chan_t'(g);
        res.b = video_pkg::chan_t'(b);
        return res;
    endfunction

    function automatic logic watch_sig(input int sel);
        case (sel)
            SIG_DE:    return vga_de;
            SIG_HSYNC: return vga_hsync;
            default:   return vga_vsync;
        endcase
    endfunction

    // Cycles counted in falling edges where outputs are settled
    task automatic wait_level(input int sel, input logic level, input int limit,
                              input string what, output int cycles);
        int n;
        n = 0;
        do begin
            @(negedge sys_clk);
            n++;
        end while (watch_sig(sel) !== level && n < limit);
        if (watch_sig(sel) !== level)
            report_timeout(what);
        cycles = n;
    endtask

    task automatic wait_fall(input int sel, input int limit, input string what,
                             output int cycles);
        int   n;
        logic prev;
        logic fell;
        n = 0;
        prev = watch_sig(sel);
        do begin
            @(negedge sys_clk);
            n++;
            fell = (prev === 1'b1) && (watch_sig(sel) === 1'b0);
            prev = watch_sig(sel);
        end while (!fell && n < limit);
        if (!fell)
            report_timeout(what);
        cycles = n;
    endtask

    task automatic set_mode_and_reset(input logic bar_byp, input logic gray_byp);
        @(posedge sys_clk);
        #2;
        bar_bypass  = bar_byp;
        gray_bypass = gray_byp;
        reset       = 1'b1;
        repeat (2) @(posedge sys_clk);
        #2;
        reset = 1'b0;
    endtask

    task automatic check_idle(input string when);
        video_pkg::rgb_t got;
        got = '{r: vga_r, g: vga_g, b: vga_b};
        check_flag(vga_hsync, 1'b1, {when, " hsync"});
        check_flag(vga_vsync, 1'b1, {when, " vsync"});
        check_flag(vga_de, 1'b0, {when, " de"});
        check_rgb(got, '0, {when, " colour"});
    endtask

    // One frame between vsync falls
    // x counted from de and y from de falls
    // only_line below zero compares every line
    task automatic check_frame(input logic bar_byp, input logic gray_byp, input int only_line);
        int               c;
        int               n;
        int               half;
        int               y;
        logic             prev_de;
        logic             prev_vs;
        logic             done;
        video_pkg::rgb_t  got;
        wait_fall(SIG_VSYNC, 2 * FRAME_CYC, "vsync fall before frame", c);
        n = 0;
        half = 0;
        y = 0;
        done = 1'b0;
        prev_de = vga_de;
        prev_vs = vga_vsync;
        while (!done) begin
            @(negedge sys_clk);
            n++;
            if (n > FRAME_CYC + LINE_CYC)
                report_timeout("end of frame");
            // Each pixel is held for two cycles and both are compared
            if (vga_de === 1'b1) begin
                got = '{r: vga_r, g: vga_g, b: vga_b};
                if (half < 2 * `H_ACTIVE && y < `V_ACTIVE &&
                    (only_line < 0 || only_line == y))
                    check_rgb(got, expected_rgb(half / 2, y, bar_byp, gray_byp),
                              $sformatf("pixel x=%0d y=%0d", half / 2, y));
                half++;
            end
            if (prev_de === 1'b1 && vga_de === 1'b0) begin
                check_count(vga_timing_pkg::hcount_t'(half / 2), `H_ACTIVE, "de pixels per line");
                half = 0;
                y++;
            end
            done = (prev_vs === 1'b1) && (vga_vsync === 1'b0);
            prev_de = vga_de;
            prev_vs = vga_vsync;
        end
        check_count(vga_timing_pkg::hcount_t'(y), `V_ACTIVE, "de lines per frame");
    endtask

    // ------------------------------------------------------------------------
    // Directed tests
    // ------------------------------------------------------------------------

    task automatic test_reset_state();
        int c;
        @(posedge sys_clk);
        #2;
        bar_bypass  = 1'b1;
        gray_bypass = 1'b1;
        reset       = 1'b1;
        @(posedge sys_clk);
        @(negedge sys_clk);
        check_idle("in reset");
        @(posedge sys_clk);
        #2;
        reset = 1'b0;
        // First edge out of reset keeps the outputs idle
        @(posedge sys_clk);
        @(negedge sys_clk);
        check_idle("after reset");
        wait_level(SIG_DE, 1'b1, 4 * FRAME_CYC, "first de after reset", c);
    endtask

    task automatic test_sync_timing();
        int c;
        set_mode_and_reset(1'b1, 1'b1);
        wait_fall(SIG_HSYNC, 2 * LINE_CYC, "first hsync fall", c);
        wait_fall(SIG_HSYNC, 2 * LINE_CYC, "second hsync fall", c);
        check_count(vga_timing_pkg::hcount_t'(c / 2), `H_TOTAL, "hsync period in pixels");
        check_count(vga_timing_pkg::hcount_t'(c % 2), 0, "hsync period odd cycles");
        wait_level(SIG_HSYNC, 1'b1, LINE_CYC, "hsync release", c);
        check_count(vga_timing_pkg::hcount_t'(c / 2), `H_SYNC, "hsync low in pixels");
        check_count(vga_timing_pkg::hcount_t'(c % 2), 0, "hsync low odd cycles");
        wait_fall(SIG_VSYNC, 2 * FRAME_CYC, "vsync fall", c);
        wait_level(SIG_VSYNC, 1'b1, FRAME_CYC, "vsync release", c);
        check_count(vga_timing_pkg::hcount_t'(c / LINE_CYC), `V_SYNC, "vsync low in lines");
        check_count(vga_timing_pkg::hcount_t'(c % LINE_CYC), 0, "vsync low partial line");
        check_frame(1'b1, 1'b1, -1);
    endtask

    task automatic test_ramp_image();
        set_mode_and_reset(1'b1, 1'b1);
        line_pick = $unsigned($random(seed)) % `V_ACTIVE;
        check_frame(1'b1, 1'b1, -1);
        // Same line again a frame later
        check_frame(1'b1, 1'b1, line_pick);
    endtask

    task automatic test_colour_bars();
        set_mode_and_reset(1'b0, 1'b1);
        line_pick = $unsigned($random(seed)) % `V_ACTIVE;
        check_frame(1'b0, 1'b1, -1);
        check_frame(1'b0, 1'b1, line_pick);
    endtask

    task automatic test_bars_gray();
        set_mode_and_reset(1'b0, 1'b0);
        check_frame(1'b0, 1'b0, -1);
    endtask

    task automatic test_bypass_change();
        int c;
        // Mode change with stale pixels still queued
        wait_fall(SIG_VSYNC, 2 * FRAME_CYC, "vsync fall before mode change", c);
        set_mode_and_reset(1'b1, 1'b0);
        // First frame skipped and the second one checked
        wait_fall(SIG_VSYNC, 2 * FRAME_CYC, "vsync fall after reset", c);
        check_frame(1'b1, 1'b0, -1);
    endtask

    // ------------------------------------------------------------------------
    // Main sequence
    // ------------------------------------------------------------------------

    initial begin
        reset       = 1'b1;
        bar_bypass  = 1'b1;
        gray_bypass = 1'b1;
        seed        = 18216;
        line_pick   = 0;
        test_reset_state();
        test_sync_timing();
        test_ramp_image();
        test_colour_bars();
        test_bars_gray();
        test_bypass_change();
        if (i_video_system_linebuffer.u_line_buffer.i_chk_fifo.fail_count == 0 &&
            i_video_system_linebuffer.u_vga_scanout.i_chk_scan.fail_count == 0) begin
            $display("Test completed successfully");
            $finish;
        end else begin
            $display("Bound checker reported assertion failures");
            stop_with_failure();
        end
    end

endmodule

/* verif/video_system_chk.sv */
`timescale 1ns/1ps

`include "video_defines.svh"

module video_system_chk (
    input  logic                sys_clk,
    input  logic                reset,
    input  video_pkg::pixel_t   src_pixel,
    input  logic                src_vld,
    input  logic                src_rdy,
    input  logic [`LB_AW:0]     wr_ptr,
    input  logic [`LB_AW:0]     rd_ptr,
    input  logic                lb_pop,
    input  logic                lb_empty,
    input  logic                vga_de,
    input  logic                vga_hsync,
    input  logic                vga_vsync
);

    // Count of failed assertions
    int fail_count = 0;

    // Entries held, from the pointer distance
    logic [`LB_AW:0] fill;

    assign fill = wr_ptr - rd_ptr;

    // ------------------------------------------------------------------------
    // Line buffer handshake
    // ------------------------------------------------------------------------

    // Scan-out only pops a filled buffer
    a_pop_not_empty: assert property (@(posedge sys_clk) disable iff (reset)
        lb_pop |-> !lb_empty)
        else begin
            $error("pop issued while line buffer empty");
            fail_count++;
        end

    // Accepted word always finds a free entry
    a_no_push_full: assert property (@(posedge sys_clk) disable iff (reset)
        (src_vld && src_rdy) |-> (fill < `LB_DEPTH))
        else begin
            $error("write accepted while line buffer full");
            fail_count++;
        end

    // Stalled producer holds its word
    a_stall_hold: assert property (@(posedge sys_clk) disable iff (reset)
        (src_vld && !src_rdy) |=> (src_vld && $stable(src_pixel)))
        else begin
            $error("producer word changed during stall");
            fail_count++;
        end

    // ------------------------------------------------------------------------
    // Scan-out blanking
    // ------------------------------------------------------------------------

    // Display enable stays off in both sync intervals
    a_de_blank: assert property (@(posedge sys_clk) disable iff (reset)
        vga_de |-> (vga_hsync && vga_vsync))
        else begin
            $error("display enable high during sync");
            fail_count++;
        end

endmodule

// FIFO side with the scan-out inputs held inactive
bind line_buffer video_system_chk i_chk_fifo (
    .sys_clk    (sys_clk),
    .reset      (reset),
    .src_pixel  (src_pixel),
    .src_vld    (src_vld),
    .src_rdy    (src_rdy),
    .wr_ptr     (wr_ptr),
    .rd_ptr     (rd_ptr),
    .lb_pop     (lb_pop),
    .lb_empty   (lb_empty),
    .vga_de     (1'b0),
    .vga_hsync  (1'b1),
    .vga_vsync  (1'b1)
);

// Scan-out side with the producer inputs held idle
bind vga_scanout video_system_chk i_chk_scan (
    .sys_clk    (sys_clk),
    .reset      (reset),
    .src_pixel  ('0),
    .src_vld    (1'b0),
    .src_rdy    (1'b1),
    .wr_ptr     ('0),
    .rd_ptr     ('0),
    .lb_pop     (lb_pop),
    .lb_empty   (lb_empty),
    .vga_de     (vga_de),
    .vga_hsync  (vga_hsync),
    .vga_vsync  (vga_vsync)
);

/* design/video_system_linebuffer.sv */
`timescale 1ns/1ps

module video_system_linebuffer (
    input  logic                sys_clk,
    input  logic                reset,
    input  logic                bar_bypass,
    input  logic                gray_bypass,
    output video_pkg::chan_t    vga_r,
    output video_pkg::chan_t    vga_g,
    output video_pkg::chan_t    vga_b,
    output logic                vga_hsync,
    output logic                vga_vsync,
    output logic                vga_de
);

    // Producer to buffer
    video_pkg::pixel_t  src_pixel;
    logic               src_vld;
    logic               src_rdy;

    // Buffer to scan-out
    video_pkg::pixel_t  lb_pixel;
    logic               lb_empty;
    logic               lb_pop;

    // ------------------------------------------------------------------------
    // Pattern producer
    // ------------------------------------------------------------------------

    pattern_core u_pattern_core (
        .sys_clk     (sys_clk),
        .reset       (reset),
        .bar_bypass  (bar_bypass),
        .gray_bypass (gray_bypass),
        .src_rdy     (src_rdy),
        .src_pixel   (src_pixel),
        .src_vld     (src_vld)
    );

    // Two-line FIFO between the pixel stages and display
    line_buffer u_line_buffer (
        .sys_clk     (sys_clk),
        .reset       (reset),
        .src_pixel   (src_pixel),
        .src_vld     (src_vld),
        .src_rdy     (src_rdy),
        .lb_pop      (lb_pop),
        .lb_pixel    (lb_pixel),
        .lb_empty    (lb_empty)
    );

    // ------------------------------------------------------------------------
    // VGA timing and pixel output
    // ------------------------------------------------------------------------

    vga_scanout u_vga_scanout (
        .sys_clk     (sys_clk),
        .reset       (reset),
        .lb_pixel    (lb_pixel),
        .lb_empty    (lb_empty),
        .lb_pop      (lb_pop),
        .vga_r       (vga_r),
        .vga_g       (vga_g),
        .vga_b       (vga_b),
        .vga_hsync   (vga_hsync),
        .vga_vsync   (vga_vsync),
        .vga_de      (vga_de)
    );

endmodule

/* design/vga_scanout.sv */
`timescale 1ns/1ps

`include "video_defines.svh"

module vga_scanout (
    input  logic                sys_clk,
    input  logic                reset,
    input  video_pkg::pixel_t   lb_pixel,
    input  logic                lb_empty,
    output logic                lb_pop,
    output video_pkg::chan_t    vga_r,
    output video_pkg::chan_t    vga_g,
    output video_pkg::chan_t    vga_b,
    output logic                vga_hsync,
    output logic                vga_vsync,
    output logic                vga_de
);

    logic                           pix_en;
    vga_timing_pkg::hcount_t        h_cnt;
    vga_timing_pkg::vcount_t        v_cnt;
    logic                           h_last;
    logic                           v_last;
    logic                           frame_end;
    logic                           active;
    logic                           h_sync_on;
    logic                           v_sync_on;
    logic                           de_nxt;
    vga_timing_pkg::scan_state_t    state;
    vga_timing_pkg::scan_state_t    state_nxt;
    video_pkg::rgb_t                out_rgb;

    // ------------------------------------------------------------------------
    // Pixel rate and raster counters
    // ------------------------------------------------------------------------

    // Half-rate enable, one pixel every two cycles
    always_ff @(posedge sys_clk) begin
        if (reset)
            pix_en <= 1'b0;
        else
            pix_en <= ~pix_en;
    end

    assign h_last    = (h_cnt == vga_timing_pkg::hcount_t'(`H_TOTAL - 1));
    assign v_last    = (v_cnt == vga_timing_pkg::vcount_t'(`V_TOTAL - 1));
    assign frame_end = h_last & v_last;

    always_ff @(posedge sys_clk) begin
        if (reset) begin
            h_cnt <= '0;
            v_cnt <= '0;
        end else if (pix_en) begin
            if (h_last) begin
                h_cnt <= '0;
                v_cnt <= v_last ? '0 : v_cnt + 1'b1;
            end else begin
                h_cnt <= h_cnt + 1'b1;
            end
        end
    end

    // Region decode
    assign active = (h_cnt < vga_timing_pkg::hcount_t'(`H_ACTIVE)) &&
                    (v_cnt < vga_timing_pkg::vcount_t'(`V_ACTIVE));
    // Sync windows start after front porch
    assign h_sync_on = (h_cnt >= `H_ACTIVE + `H_FP) &&
                       (h_cnt <  `H_ACTIVE + `H_FP + `H_SYNC);
    assign v_sync_on = (v_cnt >= `V_ACTIVE + `V_FP) &&
                       (v_cnt <  `V_ACTIVE + `V_FP + `V_SYNC);

    // ------------------------------------------------------------------------
    // Frame alignment FSM
    // ------------------------------------------------------------------------

    always_comb begin
        state_nxt = state;
        lb_pop    = 1'b0;
        de_nxt    = 1'b0;
        if (pix_en) begin
            case (state)
                vga_timing_pkg::SCAN_ALIGN: begin
                    if (!lb_empty) begin
                        // Drop stale pixels, keep the start pixel at the head
                        if (!lb_pixel.start)
                            lb_pop = 1'b1;
                        else if (frame_end)
                            state_nxt = vga_timing_pkg::SCAN_RUN;
                    end
                end
                vga_timing_pkg::SCAN_RUN: begin
                    if (active) begin
                        // Underrun loses frame phase
                        if (lb_empty) begin
                            state_nxt = vga_timing_pkg::SCAN_ALIGN;
                        end else begin
                            lb_pop = 1'b1;
                            de_nxt = 1'b1;
                        end
                    end
                end
                default: state_nxt = vga_timing_pkg::SCAN_ALIGN;
            endcase
        end
    end

    always_ff @(posedge sys_clk) begin
        if (reset)
            state <= vga_timing_pkg::SCAN_ALIGN;
        else
            state <= state_nxt;
    end

    // ------------------------------------------------------------------------
    // Output registers, held for the whole pixel period
    // ------------------------------------------------------------------------

    always_ff @(posedge sys_clk) begin
        if (reset) begin
            out_rgb   <= '0;
            vga_de    <= 1'b0;
            vga_hsync <= 1'b1;
            vga_vsync <= 1'b1;
        end else if (pix_en) begin
            // Black outside active or on underrun
            out_rgb   <= de_nxt ? lb_pixel.rgb : '0;
            vga_de    <= de_nxt;
            vga_hsync <= ~h_sync_on;
            vga_vsync <= ~v_sync_on;
        end
    end

    assign vga_r = out_rgb.r;
    assign vga_g = out_rgb.g;
    assign vga_b = out_rgb.b;

endmodule

/* design/line_buffer.sv */
`timescale 1ns/1ps

`include "video_defines.svh"

module line_buffer (
    input  logic                sys_clk,
    input  logic                reset,
    input  video_pkg::pixel_t   src_pixel,
    input  logic                src_vld,
    output logic                src_rdy,
    input  logic                lb_pop,
    output video_pkg::pixel_t   lb_pixel,
    output logic                lb_empty
);

    // Storage
    video_pkg::pixel_t  mem [`LB_DEPTH];

    // Pointers carry one extra wrap bit
    logic [`LB_AW:0]    wr_ptr;
    logic [`LB_AW:0]    rd_ptr;
    logic               full;
    logic               push;
    logic               pop;

    // ------------------------------------------------------------------------
    // Status
    // ------------------------------------------------------------------------

    // Same address on a different lap means full
    assign full = (wr_ptr[`LB_AW] != rd_ptr[`LB_AW]) &&
                  (wr_ptr[`LB_AW-1:0] == rd_ptr[`LB_AW-1:0]);
    assign lb_empty = (wr_ptr == rd_ptr);

    // Back-pressure to the producer
    assign src_rdy = ~full;

    assign push = src_vld & src_rdy;
    // Guard against popping an empty buffer
    assign pop  = lb_pop & ~lb_empty;

    // ------------------------------------------------------------------------
    // Write side
    // ------------------------------------------------------------------------

    always_ff @(posedge sys_clk) begin
        if (push)
            mem[wr_ptr[`LB_AW-1:0]] <= src_pixel;
    end

    // ------------------------------------------------------------------------
    // Pointers
    // ------------------------------------------------------------------------

    // Push and pop in the same cycle move both pointers
    always_ff @(posedge sys_clk) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (push)
                wr_ptr <= wr_ptr + 1'b1;
            if (pop)
                rd_ptr <= rd_ptr + 1'b1;
        end
    end

    // Head entry straight out
    // Visible one cycle after its write
    assign lb_pixel = mem[rd_ptr[`LB_AW-1:0]];

endmodule

/* design/pattern_core.sv */
`timescale 1ns/1ps

`include "video_defines.svh"

module pattern_core (
    input  logic                sys_clk,
    input  logic                reset,
    input  logic                bar_bypass,
    input  logic                gray_bypass,
    input  logic                src_rdy,
    output video_pkg::pixel_t   src_pixel,
    output logic                src_vld
);

    localparam video_pkg::chan_t CH_FULL = '1;
    localparam video_pkg::chan_t CH_ZERO = '0;

    vga_timing_pkg::hcount_t    x_cnt;
    vga_timing_pkg::vcount_t    y_cnt;
    logic                       load;
    logic [2:0]                 bar_idx;
    video_pkg::rgb_t            base_rgb;
    video_pkg::rgb_t            bar_rgb;
    video_pkg::rgb_t            mix_rgb;
    video_pkg::rgb_t            out_rgb;
    logic [`CH_SIZE+1:0]        gray_sum;

    // ------------------------------------------------------------------------
    // Raster position over the active area
    // ------------------------------------------------------------------------

    // Advance when the register is empty or its word was taken
    assign load = ~src_vld | src_rdy;

    always_ff @(posedge sys_clk) begin
        if (reset) begin
            x_cnt   <= '0;
            y_cnt   <= '0;
            src_vld <= 1'b0;
        end else if (load) begin
            src_vld <= 1'b1;
            if (x_cnt == vga_timing_pkg::hcount_t'(`H_ACTIVE - 1)) begin
                x_cnt <= '0;
                // Frame wraps after the last active line
                if (y_cnt == vga_timing_pkg::vcount_t'(`V_ACTIVE - 1))
                    y_cnt <= '0;
                else
                    y_cnt <= y_cnt + 1'b1;
            end else begin
                x_cnt <= x_cnt + 1'b1;
            end
        end
    end

    // ------------------------------------------------------------------------
    // Colour generation
    // ------------------------------------------------------------------------

    // Base ramp, red up and blue down across the line
    assign base_rgb.r = video_pkg::chan_t'(x_cnt);
    assign base_rgb.g = video_pkg::chan_t'(y_cnt) << 2;
    assign base_rgb.b = CH_FULL - video_pkg::chan_t'(x_cnt);

    // Bar index from column
    assign bar_idx = 3'(x_cnt / `BAR_WIDTH);

    // Eight fixed bars, left to right
    always_comb begin
        case (bar_idx)
            3'd0:    bar_rgb = '{r: CH_FULL, g: CH_FULL, b: CH_FULL};  // white
            3'd1:    bar_rgb = '{r: CH_FULL, g: CH_FULL, b: CH_ZERO};  // yellow
            3'd2:    bar_rgb = '{r: CH_ZERO, g: CH_FULL, b: CH_FULL};  // cyan
            3'd3:    bar_rgb = '{r: CH_ZERO, g: CH_FULL, b: CH_ZERO};  // green
            3'd4:    bar_rgb = '{r: CH_FULL, g: CH_ZERO, b: CH_FULL};  // magenta
            3'd5:    bar_rgb = '{r: CH_FULL, g: CH_ZERO, b: CH_ZERO};  // red
            3'd6:    bar_rgb = '{r: CH_ZERO, g: CH_ZERO, b: CH_FULL};  // blue
            default: bar_rgb = '{r: CH_ZERO, g: CH_ZERO, b: CH_ZERO};  // black
        endcase
    end

    // Overlay stage
    assign mix_rgb = bar_bypass ? base_rgb : bar_rgb;

    // Luma approximation (r + 2g + b) / 4
    assign gray_sum = {2'b00, mix_rgb.r} + {1'b0, mix_rgb.g, 1'b0} + {2'b00, mix_rgb.b};

    // Gray stage, truncating divide
    always_comb begin
        if (gray_bypass) begin
            out_rgb = mix_rgb;
        end else begin
            out_rgb.r = gray_sum[`CH_SIZE+1:2];
            out_rgb.g = gray_sum[`CH_SIZE+1:2];
            out_rgb.b = gray_sum[`CH_SIZE+1:2];
        end
    end

    // ------------------------------------------------------------------------
    // Output register, held while stalled
    // ------------------------------------------------------------------------

    always_ff @(posedge sys_clk) begin
        if (load) begin
            src_pixel.rgb   <= out_rgb;
            src_pixel.start <= (x_cnt == '0) && (y_cnt == '0);
        end
    end

endmodule

/* design/vga_timing_pkg.sv */
`include "video_defines.svh"

package vga_timing_pkg;

    // Counter widths sized to cover the full line and frame
    typedef logic [$clog2(`H_TOTAL)-1:0] hcount_t;
    typedef logic [$clog2(`V_TOTAL)-1:0] vcount_t;

    // Scan-out alignment machine
    // ALIGN drops pixels until a start pixel sits at the head
    // RUN displays one pixel per active position
    typedef enum logic {
        SCAN_ALIGN = 1'b0,
        SCAN_RUN   = 1'b1
    } scan_state_t;

endpackage

/* design/video_pkg.sv */
`include "video_defines.svh"

package video_pkg;

    // One colour channel
    typedef logic [`CH_SIZE-1:0] chan_t;

    // Full colour triple, red in the top bits
    typedef struct packed {
        chan_t r;
        chan_t g;
        chan_t b;
    } rgb_t;

    // Word carried by the line buffer
    // start marks the first active pixel of a frame
    typedef struct packed {
        logic start;
        rgb_t rgb;
    } pixel_t;

endpackage

/* design/video_defines.svh */
`ifndef VIDEO_DEFINES_SVH
`define VIDEO_DEFINES_SVH

// ---------------------------------------------------------------------------
// Pixel format
// ---------------------------------------------------------------------------

// Bits per colour channel
`define CH_SIZE     4

// ---------------------------------------------------------------------------
// Display timing, in pixel periods and lines
// ---------------------------------------------------------------------------

// Horizontal
`define H_ACTIVE    16
`define H_FP        2
`define H_SYNC      4
`define H_BP        2
`define H_TOTAL     (`H_ACTIVE + `H_FP + `H_SYNC + `H_BP)

// Vertical
`define V_ACTIVE    4
`define V_FP        1
`define V_SYNC      2
`define V_BP        1
`define V_TOTAL     (`V_ACTIVE + `V_FP + `V_SYNC + `V_BP)

// Colour bar width in columns, eight bars across
`define BAR_WIDTH   (`H_ACTIVE / 8)

// ---------------------------------------------------------------------------
// Line buffer
// ---------------------------------------------------------------------------

// Two full lines of storage
`define LB_DEPTH    32
`define LB_AW       5

`endif
